//--- build.f
rob_pkg.sv
tag_match_cam.sv
reorder_table.sv
rob_top.sv
tb_clock_gen.sv
rob_tb.sv

//--- reorder_table.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_table #(
	parameter int issue_width = 2,
	parameter int rob_depth   = 8
) (
	input  logic                                       clock,
	input  logic                                       rst_n,
	input  rob_pkg::dispatch_slot_t [issue_width-1:0]  dispatch_in,
	input  logic                                       retire_en,
	input  logic                                       flush,
	input  logic [rob_depth-1:0]                       phys_hits,
	input  logic [rob_depth-1:0]                       store_hits,
	output rob_pkg::phys_tag_t [rob_depth-1:0]         phys_keys,
	output rob_pkg::sq_idx_t [rob_depth-1:0]           store_keys,
	output rob_pkg::retire_slot_t [issue_width-1:0]    retire_out,
	output rob_pkg::rob_count_t                        free_rows,
	output logic                                       dispatch_stall
);

	import rob_pkg::*;

	// free count after reset or flush
	localparam rob_count_t depth_count = rob_count_t'(rob_depth);

	// row array and its next state
	rob_entry_t [rob_depth-1:0] rows;
	rob_entry_t [rob_depth-1:0] rows_next;

	// head is the oldest row, tail the next row to fill
	rob_ptr_t head;
	rob_ptr_t tail;

	// completion seen this cycle, already filtered
	logic [rob_depth-1:0] done_set;

	// retire scan
	logic [issue_width-1:0]     retire_lane;
	rob_ptr_t [issue_width-1:0] retire_idx;
	rob_count_t                 retire_cnt;

	// dispatch
	logic [issue_width-1:0]     slot_valid;
	logic [issue_width-1:0]     dispatch_lane;
	rob_ptr_t [issue_width-1:0] dispatch_idx;
	rob_count_t                 dispatch_cnt;

	// pointer step with wrap at rob_depth
	function automatic rob_ptr_t ptr_add(rob_ptr_t base, int unsigned offs);
		int unsigned sum;
		sum = int'(base) + offs;
		return rob_ptr_t'(sum % rob_depth);
	endfunction

	// keys for both cams, straight from the rows
	always_comb begin
		for (int r = 0; r < rob_depth; r++) begin
			phys_keys[r]  = rows[r].t_new;
			store_keys[r] = rows[r].sq_idx;
			// stores listen to the store queue only
			// everything else listens to the cdb
			if (rows[r].is_store) begin
				done_set[r] = rows[r].busy & store_hits[r];
			end else begin
				done_set[r] = rows[r].busy & phys_hits[r];
			end
		end
	end

	// in-order retire from head
	// uses registered done bits, so a completion retires one cycle later
	always_comb begin
		logic chain;
		// no lane valid under back-pressure or flush
		chain      = retire_en & ~flush;
		retire_cnt = '0;
		for (int i = 0; i < issue_width; i++) begin
			retire_idx[i] = ptr_add(head, i);
			// stop at first row not done
			chain          = chain & rows[retire_idx[i]].busy & rows[retire_idx[i]].done;
			retire_lane[i] = chain;
			retire_out[i]  = '{
				valid:    chain,
				halt:     rows[retire_idx[i]].halt,
				t_new:    rows[retire_idx[i]].t_new,
				t_old:    rows[retire_idx[i]].t_old,
				arch_reg: rows[retire_idx[i]].arch_reg
			};
			if (chain) begin
				retire_cnt = retire_cnt + 1'b1;
			end
		end
	end

	// stall from the registered count only
	assign dispatch_stall = (free_rows < rob_count_t'(issue_width));

	// dispatch lanes fill consecutive rows from tail
	always_comb begin
		logic chain;
		// slots under stall are dropped
		chain        = ~dispatch_stall;
		dispatch_cnt = '0;
		for (int i = 0; i < issue_width; i++) begin
			slot_valid[i]   = dispatch_in[i].valid;
			dispatch_idx[i] = ptr_add(tail, i);
			chain            = chain & slot_valid[i];
			dispatch_lane[i] = chain;
			if (chain) begin
				dispatch_cnt = dispatch_cnt + 1'b1;
			end
		end
	end

	// row next state
	// done first, then retire clears, then dispatch writes
	always_comb begin
		rows_next = rows;
		for (int r = 0; r < rob_depth; r++) begin
			if (done_set[r]) begin
				rows_next[r].done = 1'b1;
			end
		end
		for (int i = 0; i < issue_width; i++) begin
			if (retire_lane[i]) begin
				rows_next[retire_idx[i]] = empty_entry;
			end
		end
		// tail rows are free whenever stall is low
		for (int i = 0; i < issue_width; i++) begin
			if (dispatch_lane[i]) begin
				rows_next[dispatch_idx[i]] = '{
					busy:     1'b1,
					done:     dispatch_in[i].pre_done,
					is_store: dispatch_in[i].is_store,
					halt:     dispatch_in[i].halt,
					t_new:    dispatch_in[i].t_new,
					t_old:    dispatch_in[i].t_old,
					arch_reg: dispatch_in[i].arch_reg,
					sq_idx:   dispatch_in[i].sq_idx
				};
			end
		end
	end

	// state update, flush behaves like reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < rob_depth; r++) begin
				rows[r] <= empty_entry;
			end
			head      <= '0;
			tail      <= '0;
			free_rows <= depth_count;
		end else if (flush) begin
			// dispatch and retire of this cycle are lost
			for (int r = 0; r < rob_depth; r++) begin
				rows[r] <= empty_entry;
			end
			head      <= '0;
			tail      <= '0;
			free_rows <= depth_count;
		end else begin
			rows      <= rows_next;
			head      <= ptr_add(head, retire_cnt);
			tail      <= ptr_add(tail, dispatch_cnt);
			free_rows <= free_rows + retire_cnt - dispatch_cnt;
		end
	end

	// rename must hold its slots while stalled
	a_no_dispatch_in_stall: assert property (
		@(posedge clock) disable iff (!rst_n)
		dispatch_stall |-> (slot_valid == '0)
	) else $error("dispatch slot valid while stalled");

	// valid lanes form a prefix from lane 0
	// a prefix mask plus one shares no bit with itself
	a_slots_in_order: assert property (
		@(posedge clock) disable iff (!rst_n)
		(slot_valid & (slot_valid + 1'b1)) == '0
	) else $error("valid slot after invalid slot: %b", slot_valid);

	// count never runs past the table size
	a_free_in_range: assert property (
		@(posedge clock) disable iff (!rst_n)
		free_rows <= depth_count
	) else $error("free_rows above depth: %0d", free_rows);

endmodule

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none

package rob_pkg;

	// machine sizes, also the top-level parameter defaults
	localparam int issue_width   = 2;
	localparam int rob_depth     = 8;
	localparam int phys_tag_bits = 6;
	localparam int arch_reg_bits = 5;
	localparam int sq_idx_bits   = 3;

	// derived pointer and counter widths
	localparam int rob_ptr_bits   = $clog2(rob_depth);
	// counter holds 0 to rob_depth inclusive
	localparam int rob_count_bits = $clog2(rob_depth + 1);

	typedef logic [phys_tag_bits-1:0]  phys_tag_t;
	typedef logic [arch_reg_bits-1:0]  arch_reg_t;
	typedef logic [sq_idx_bits-1:0]    sq_idx_t;
	typedef logic [rob_ptr_bits-1:0]   rob_ptr_t;
	typedef logic [rob_count_bits-1:0] rob_count_t;

	// one dispatch lane from rename
	typedef struct packed {
		logic      valid;
		logic      is_store;
		// no result to wait for, enters the table done
		logic      pre_done;
		logic      halt;
		phys_tag_t t_new;
		phys_tag_t t_old;
		arch_reg_t arch_reg;
		sq_idx_t   sq_idx;
	} dispatch_slot_t;

	// one table row
	typedef struct packed {
		logic      busy;
		logic      done;
		logic      is_store;
		logic      halt;
		phys_tag_t t_new;
		phys_tag_t t_old;
		arch_reg_t arch_reg;
		sq_idx_t   sq_idx;
	} rob_entry_t;

	// one commit lane, t_new and t_old go back to free list and map table
	typedef struct packed {
		logic      valid;
		logic      halt;
		phys_tag_t t_new;
		phys_tag_t t_old;
		arch_reg_t arch_reg;
	} retire_slot_t;

	// one common data bus broadcast
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} cdb_tag_t;

	// one finished store from the store queue
	typedef struct packed {
		logic    valid;
		sq_idx_t idx;
	} sq_done_t;

	// reset and flush value of a row
	localparam rob_entry_t empty_entry = '0;

endpackage

`default_nettype wire

//--- rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

	import rob_pkg::*;

	// phase lengths in cycles
	localparam int reset_cycles  = 5;
	localparam int driven_cycles = 6 + 40 + 20 + 40 + 21 + 300;
	localparam int cycle_limit   = reset_cycles + driven_cycles + 50;

	logic                             clock;
	logic                             rst_n;
	dispatch_slot_t [issue_width-1:0] dispatch_in;
	cdb_tag_t [issue_width-1:0]       cdb_in;
	sq_done_t [issue_width-1:0]       sq_done_in;
	logic                             retire_en;
	logic                             flush;
	retire_slot_t [issue_width-1:0]   retire_out;
	rob_count_t                       free_rows;
	logic                             dispatch_stall;

	// reference model with the oldest entry at index 0
	dispatch_slot_t model_q[$];
	bit             done_q[$];

	// running keys stay unique over at most rob_depth live entries
	phys_tag_t   next_tag;
	sq_idx_t     next_sq;
	int unsigned cycle_count = 0;
	int unsigned checked_cycles = 0;

	tb_clock_gen #(.period(100.0)) clock_src (.clock(clock));

	rob_top #(
		.issue_width (issue_width),
		.rob_depth   (rob_depth)
	) uut (
		.clock          (clock),
		.rst_n          (rst_n),
		.dispatch_in    (dispatch_in),
		.cdb_in         (cdb_in),
		.sq_done_in     (sq_done_in),
		.retire_en      (retire_en),
		.flush          (flush),
		.retire_out     (retire_out),
		.free_rows      (free_rows),
		.dispatch_stall (dispatch_stall)
	);

	// expected lanes and count from model state and current levels
	function automatic void expect_outputs(input dispatch_slot_t q[$], input bit d[$],
		input logic ren, input logic fl,
		output retire_slot_t [issue_width-1:0] exp_ret, output rob_count_t exp_free);
		bit chain;
		chain = ren && !fl;
		for (int i = 0; i < issue_width; i++) begin
			exp_ret[i] = '0;
			// consecutive done entries from the head
			if (i < q.size()) begin
				chain = chain && d[i];
			end else begin
				chain = 1'b0;
			end
			if (chain) begin
				exp_ret[i] = '{valid: 1'b1, halt: q[i].halt, t_new: q[i].t_new,
					t_old: q[i].t_old, arch_reg: q[i].arch_reg};
			end
		end
		exp_free = rob_count_t'(rob_depth - q.size());
	endfunction

	// invalid lanes carry don't-care fields
	task automatic check_retire(input int lane, input retire_slot_t exp, input retire_slot_t act);
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			$display("Error at %0t ns: retire_out[%0d] expected %h actual %h",
				$time, lane, exp, act);
			$display("TEST FAILED");
			$fatal(1, "retire lane mismatch");
		end
	endtask

	task automatic check_free(input rob_count_t exp, input rob_count_t act);
		if (act !== exp) begin
			$display("Error at %0t ns: free_rows expected %0d actual %0d",
				$time, exp, act);
			$display("TEST FAILED");
			$fatal(1, "free count mismatch");
		end
	endtask

	task automatic check_stall(input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error at %0t ns: dispatch_stall expected %b actual %b",
				$time, exp, act);
			$display("TEST FAILED");
			$fatal(1, "stall mismatch");
		end
	endtask

	// retire, then completions, then new entries at the tail
	task automatic update_model(input retire_slot_t [issue_width-1:0] exp_ret, input bit stall);
		bit chain;
		chain = !stall;
		if (flush) begin
			model_q.delete();
			done_q.delete();
		end else begin
			for (int i = 0; i < issue_width; i++) begin
				if (exp_ret[i].valid) begin
					void'(model_q.pop_front());
					void'(done_q.pop_front());
				end
			end
			for (int e = 0; e < model_q.size(); e++) begin
				for (int k = 0; k < issue_width; k++) begin
					if (!model_q[e].is_store && cdb_in[k].valid
						&& cdb_in[k].tag == model_q[e].t_new)
						done_q[e] = 1'b1;
					if (model_q[e].is_store && sq_done_in[k].valid
						&& sq_done_in[k].idx == model_q[e].sq_idx)
						done_q[e] = 1'b1;
				end
			end
			for (int i = 0; i < issue_width; i++) begin
				chain = chain && dispatch_in[i].valid;
				if (chain) begin
					model_q.push_back(dispatch_in[i]);
					done_q.push_back(dispatch_in[i].pre_done);
				end
			end
		end
	endtask

	// outputs sampled before the table registers update
	always @(posedge clock) begin
		retire_slot_t [issue_width-1:0] exp_ret;
		rob_count_t                     exp_free;
		if (rst_n) begin
			expect_outputs(model_q, done_q, retire_en, flush, exp_ret, exp_free);
			for (int i = 0; i < issue_width; i++) begin
				check_retire(i, exp_ret[i], retire_out[i]);
			end
			check_free(exp_free, free_rows);
			check_stall(exp_free < rob_count_t'(issue_width), dispatch_stall);
			update_model(exp_ret, exp_free < rob_count_t'(issue_width));
			checked_cycles++;
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// one cycle of stimulus set up on the falling edge
	task automatic drive_cycle(input int n_disp, input int pre_pct, input int bc_pct,
		input logic ren, input logic fl);
		int pick;
		@(negedge clock);
		dispatch_in = '0;
		cdb_in      = '0;
		sq_done_in  = '0;
		retire_en   = ren;
		flush       = fl;
		// no slots while the table is nearly full
		if (model_q.size() > rob_depth - issue_width)
			n_disp = 0;
		for (int i = 0; i < n_disp; i++) begin
			dispatch_in[i].valid    = 1'b1;
			dispatch_in[i].is_store = ($urandom_range(0, 3) == 0);
			dispatch_in[i].pre_done = ($urandom_range(0, 99) < pre_pct);
			dispatch_in[i].halt     = ($urandom_range(0, 15) == 0);
			dispatch_in[i].t_new    = next_tag;
			dispatch_in[i].t_old    = phys_tag_t'($urandom);
			dispatch_in[i].arch_reg = arch_reg_t'($urandom);
			dispatch_in[i].sq_idx   = next_sq;
			next_tag++;
			if (dispatch_in[i].is_store)
				next_sq++;
		end
		for (int k = 0; k < issue_width; k++) begin
			if ($urandom_range(0, 99) < bc_pct) begin
				cdb_in[k]     = '{valid: 1'b1, tag: phys_tag_t'($urandom)};
				sq_done_in[k] = '{valid: 1'($urandom_range(0, 1)), idx: sq_idx_t'($urandom)};
				// mostly aimed at a live entry or else likely a miss
				if (model_q.size() > 0 && $urandom_range(0, 3) != 0) begin
					pick              = $urandom_range(0, model_q.size() - 1);
					cdb_in[k].tag     = model_q[pick].t_new;
					sq_done_in[k].idx = model_q[pick].sq_idx;
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'hc6d5));
		rst_n       = 1'b0;
		dispatch_in = '0;
		cdb_in      = '0;
		sq_done_in  = '0;
		retire_en   = 1'b0;
		flush       = 1'b0;
		next_tag    = '0;
		next_sq     = '0;
		repeat (reset_cycles) @(negedge clock);
		rst_n = 1'b1;
		// fill until stall with nothing completing
		repeat (6) drive_cycle(2, 0, 0, 1'b1, 1'b0);
		// out-of-order completion
		repeat (40) drive_cycle($urandom_range(0, 2), 0, 70, 1'b1, 1'b0);
		// pre_done only
		repeat (20) drive_cycle($urandom_range(0, 2), 100, 0, 1'b1, 1'b0);
		// back-pressure
		repeat (40) drive_cycle($urandom_range(0, 2), 20, 60, 1'($urandom_range(0, 1)), 1'b0);
		// flush in mid-traffic
		repeat (10) drive_cycle(2, 30, 50, 1'b1, 1'b0);
		drive_cycle(2, 30, 50, 1'b1, 1'b1);
		repeat (10) drive_cycle($urandom_range(0, 2), 30, 50, 1'b1, 1'b0);
		// long mix with pointer wrap
		repeat (300) drive_cycle($urandom_range(0, 2), 25, 60,
			($urandom_range(0, 3) != 0), ($urandom_range(0, 49) == 0));
		@(negedge clock);
		if (checked_cycles < driven_cycles) begin
			$display("only %0d cycles were checked", checked_cycles);
			$display("TEST FAILED");
			$fatal(1, "checker did not run");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
	parameter int issue_width = rob_pkg::issue_width,
	parameter int rob_depth   = rob_pkg::rob_depth
) (
	input  logic                                      clock,
	input  logic                                      rst_n,
	input  rob_pkg::dispatch_slot_t [issue_width-1:0] dispatch_in,
	input  rob_pkg::cdb_tag_t [issue_width-1:0]       cdb_in,
	input  rob_pkg::sq_done_t [issue_width-1:0]       sq_done_in,
	input  logic                                      retire_en,
	input  logic                                      flush,
	output rob_pkg::retire_slot_t [issue_width-1:0]   retire_out,
	output rob_pkg::rob_count_t                       free_rows,
	output logic                                      dispatch_stall
);

	import rob_pkg::*;

	// broadcast lanes split into enables and keys
	logic [issue_width-1:0]      cdb_en;
	phys_tag_t [issue_width-1:0] cdb_keys;
	logic [issue_width-1:0]      sq_en;
	sq_idx_t [issue_width-1:0]   sq_keys;

	// row keys out of the table, hits back in
	phys_tag_t [rob_depth-1:0] phys_keys;
	sq_idx_t [rob_depth-1:0]   store_keys;
	logic [rob_depth-1:0]      phys_hits;
	logic [rob_depth-1:0]      store_hits;

	for (genvar i = 0; i < issue_width; i++) begin : g_lane
		assign cdb_en[i]   = cdb_in[i].valid;
		assign cdb_keys[i] = cdb_in[i].tag;
		assign sq_en[i]    = sq_done_in[i].valid;
		assign sq_keys[i]  = sq_done_in[i].idx;
	end

	// result tags against t_new of every row
	tag_match_cam #(
		.num_keys (issue_width),
		.num_rows (rob_depth),
		.key_t    (phys_tag_t)
	) phys_cam (
		.key_en   (cdb_en),
		.keys     (cdb_keys),
		.row_keys (phys_keys),
		.hits     (phys_hits)
	);

	// finished store indices against sq_idx of every row
	tag_match_cam #(
		.num_keys (issue_width),
		.num_rows (rob_depth),
		.key_t    (sq_idx_t)
	) store_cam (
		.key_en   (sq_en),
		.keys     (sq_keys),
		.row_keys (store_keys),
		.hits     (store_hits)
	);

	// table decides which hits count per row
	reorder_table #(
		.issue_width (issue_width),
		.rob_depth   (rob_depth)
	) rob_table (
		.clock          (clock),
		.rst_n          (rst_n),
		.dispatch_in    (dispatch_in),
		.retire_en      (retire_en),
		.flush          (flush),
		.phys_hits      (phys_hits),
		.store_hits     (store_hits),
		.phys_keys      (phys_keys),
		.store_keys     (store_keys),
		.retire_out     (retire_out),
		.free_rows      (free_rows),
		.dispatch_stall (dispatch_stall)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f build.f -o rob_sim

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/rob_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- tag_match_cam.sv
`timescale 1ns/1ps
`default_nettype none

module tag_match_cam #(
	parameter int  num_keys = 2,
	parameter int  num_rows = 8,
	parameter type key_t    = logic [5:0]
) (
	// one enable per broadcast lane
	input  logic [num_keys-1:0]   key_en,
	input  key_t [num_keys-1:0]   keys,
	// stored key of every table row
	input  key_t [num_rows-1:0]   row_keys,
	// row matched by any enabled lane
	output logic [num_rows-1:0]   hits
);

	// full compare, every row against every lane
	always_comb begin
		for (int r = 0; r < num_rows; r++) begin
			hits[r] = 1'b0;
			// or over all lanes, a disabled lane never hits
			for (int k = 0; k < num_keys; k++) begin
				if (key_en[k] && (keys[k] == row_keys[r])) begin
					hits[r] = 1'b1;
				end
			end
		end
	end

	// enables come from the bus drivers in other blocks
	// an unknown enable would set done bits at random
	always_comb begin
		a_key_en_known: assert final (!$isunknown(key_en))
			else $error("cam enable unknown: %b", key_en);
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real period = 100.0
) (
	output logic clock
);

	// free-running, low first
	initial begin
		clock = 1'b0;
		forever begin
			#(period / 2.0);
			clock = ~clock;
		end
	end

endmodule

`default_nettype wire
